/* all.f */
design/usb_bus_pkg.sv
design/capture_pkg.sv
design/usb_reg_port.sv
design/ctrl_regs.sv
design/capture_fifo.sv
design/status_outputs.sv
design/cw_capture_top.sv
bench/tb_cw_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Finished with no errors"

verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_cw_capture \
   -f all.f -o tb_cw_capture
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_cw_capture > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^${PASS_MSG}\$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/tb_cw_capture.sv */
module tb_cw_capture;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 10;
   localparam int FIFO_DEPTH = 16;
   localparam int FLASH_DIV  = 8;

   // watchdog allows twice the summed cycle budgets
   localparam int BUDGET_READBACK = 60;
   localparam int BUDGET_TRACE    = 400;
   localparam int BUDGET_SRC_SEL  = 250;
   localparam int BUDGET_OVERFLOW = 500;
   localparam int BUDGET_DEBUG    = 150;
   localparam int TIMEOUT_CYCLES  = 2 * (BUDGET_READBACK + BUDGET_TRACE + BUDGET_SRC_SEL +
                                         BUDGET_OVERFLOW + BUDGET_DEBUG);

   logic        clk_usb_buf;
   logic        rst_n;
   logic [7:0]  usb_addr;
   logic [7:0]  usb_wdata;
   logic        usb_rdn;
   logic        usb_wrn;
   logic        usb_cen;
   logic [7:0]  usb_rdata;
   logic        usb_data_oe;
   logic        trace_wr;
   logic [15:0] trace_data;
   logic        la_wr;
   logic [15:0] la_data;
   logic        led_err;
   logic        led_cap;
   logic [7:0]  userio_d;
   logic [7:0]  userio_oe;

   logic [15:0] model_q [$];  // expected FIFO contents head first
   logic [15:0] model_last;
   logic        model_src;
   logic        model_ovf;
   integer      seed;
   int          checks;
   int          errors;
   int          test_err_start;
   string       test_name;

   cw_capture_top #(
      .FIFO_DEPTH    (FIFO_DEPTH),
      .FLASH_DIV     (FLASH_DIV)
   ) UUT (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n),
      .usb_addr_i    (usb_addr),
      .usb_data_i    (usb_wdata),
      .usb_rdn_i     (usb_rdn),
      .usb_wrn_i     (usb_wrn),
      .usb_cen_i     (usb_cen),
      .usb_data_o    (usb_rdata),
      .usb_data_oe_o (usb_data_oe),
      .trace_wr_i    (trace_wr),
      .trace_data_i  (trace_data),
      .la_wr_i       (la_wr),
      .la_data_i     (la_data),
      .led_err_o     (led_err),
      .led_cap_o     (led_cap),
      .userio_d_o    (userio_d),
      .userio_oe_o   (userio_oe)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("ERR %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
      end
   endtask

   function automatic logic [15:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   function automatic logic [7:0] ctrl_byte(input logic src, input logic flush, input logic clr);
      logic [7:0] v;
      v = '0;
      v[usb_bus_pkg::CTRL_SRC_BIT]     = src;
      v[usb_bus_pkg::CTRL_FLUSH_BIT]   = flush;
      v[usb_bus_pkg::CTRL_CLR_ERR_BIT] = clr;
      return v;
   endfunction

   // strobes low for 4 cycles then 2 idle cycles
   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_addr  <= addr;
      usb_wdata <= data;
      usb_cen   <= 1'b0;
      usb_wrn   <= 1'b0;
      repeat (4) @(posedge clk_usb_buf);
      usb_wrn <= 1'b1;
      usb_cen <= 1'b1;
      repeat (2) @(posedge clk_usb_buf);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk_usb_buf);
      usb_addr <= addr;
      usb_cen  <= 1'b0;
      usb_rdn  <= 1'b0;
      repeat (3) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);  // last half cycle of the low period
      data = usb_rdata;
      check_value("read data enable", 32'(1'b1), 32'(usb_data_oe));
      @(posedge clk_usb_buf);
      usb_rdn <= 1'b1;
      usb_cen <= 1'b1;
      repeat (2) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);  // bus released 2 cycles after rdn rises
      check_value("read data enable released", 32'(1'b0), 32'(usb_data_oe));
   endtask

   // one word offered for one cycle
   task automatic offer_word(input logic is_la, input logic [15:0] w);
      @(posedge clk_usb_buf);
      if (is_la) begin
         la_wr   <= 1'b1;
         la_data <= w;
      end else begin
         trace_wr   <= 1'b1;
         trace_data <= w;
      end
      @(posedge clk_usb_buf);
      la_wr    <= 1'b0;
      trace_wr <= 1'b0;
      if (is_la == model_src) begin  // only the selected source is stored
         if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(w);
            model_last = w;
         end else begin
            model_ovf = 1'b1;
         end
      end
   endtask

   task automatic read_word_check();
      logic [15:0] exp;
      logic [7:0]  lo;
      logic [7:0]  hi;
      exp = model_q.pop_front();
      bus_read(usb_bus_pkg::REG_FIFO_DATA, lo);
      bus_read(usb_bus_pkg::REG_FIFO_DATA, hi);
      check_value("fifo low byte", 32'(exp[7:0]), 32'(lo));
      check_value("fifo high byte", 32'(exp[15:8]), 32'(hi));
   endtask

   task automatic check_status();
      logic [7:0] exp;
      logic [7:0] r;
      logic [5:0] cnt;
      cnt = 6'(model_q.size());
      exp = '0;
      exp[7:3]                    = cnt[4:0];  // low five count bits
      exp[capture_pkg::STAT_OVF]   = model_ovf;
      exp[capture_pkg::STAT_FULL]  = (model_q.size() == FIFO_DEPTH);
      exp[capture_pkg::STAT_EMPTY] = (model_q.size() == 0);
      bus_read(usb_bus_pkg::REG_STATUS, r);
      check_value("status", 32'(exp), 32'(r));
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      test_err_start = errors;
   endtask

   task automatic finish_test();
      $display("test %s done, %0d errors", test_name, errors - test_err_start);
   endtask

   initial begin
      logic [7:0] d;
      logic [7:0] dir;
      logic [7:0] r;
      logic       seen_hi;
      logic       seen_lo;
      seed       = 92;
      checks     = 0;
      errors     = 0;
      model_src  = capture_pkg::SRC_TRACE;
      model_ovf  = 1'b0;
      model_last = '0;
      rst_n      <= 1'b0;
      usb_addr   <= '0;
      usb_wdata  <= '0;
      usb_rdn    <= 1'b1;
      usb_wrn    <= 1'b1;
      usb_cen    <= 1'b1;
      trace_wr   <= 1'b0;
      trace_data <= '0;
      la_wr      <= 1'b0;
      la_data    <= '0;
      repeat (2) @(posedge clk_usb_buf);
      rst_n <= 1'b1;
      @(posedge clk_usb_buf);

      start_test("readback");
      d   = 8'(rand_word());
      dir = 8'(rand_word());
      bus_write(usb_bus_pkg::REG_USERIO_DATA, d);
      bus_write(usb_bus_pkg::REG_USERIO_DIR, dir);
      bus_read(usb_bus_pkg::REG_USERIO_DATA, r);
      check_value("userio data reg", 32'(d), 32'(r));
      bus_read(usb_bus_pkg::REG_USERIO_DIR, r);
      check_value("userio dir reg", 32'(dir), 32'(r));
      @(negedge clk_usb_buf);
      check_value("userio_d pins", 32'(d), 32'(userio_d));
      check_value("userio_oe pins", 32'(dir), 32'(userio_oe));
      finish_test();

      start_test("trace_capture");
      model_src = capture_pkg::SRC_TRACE;
      bus_write(usb_bus_pkg::REG_CTRL, ctrl_byte(model_src, 1'b0, 1'b0));
      for (int i = 0; i < 10; i++) offer_word(capture_pkg::SRC_TRACE, rand_word());
      check_status();
      for (int i = 0; i < 10; i++) begin
         read_word_check();
         check_status();
      end
      bus_read(usb_bus_pkg::REG_FIFO_DATA, r);
      check_value("empty fifo read", 32'(0), 32'(r));
      check_status();
      finish_test();

      start_test("source_select");
      model_src = capture_pkg::SRC_LA;
      bus_write(usb_bus_pkg::REG_CTRL, ctrl_byte(model_src, 1'b0, 1'b0));
      for (int i = 0; i < 8; i++) begin
         offer_word(capture_pkg::SRC_TRACE, rand_word());  // must be ignored
         offer_word(capture_pkg::SRC_LA, rand_word());
      end
      check_status();
      for (int i = 0; i < 8; i++) read_word_check();
      check_status();
      finish_test();

      start_test("overflow");
      model_src = capture_pkg::SRC_TRACE;
      bus_write(usb_bus_pkg::REG_CTRL, ctrl_byte(model_src, 1'b0, 1'b0));
      for (int i = 0; i < 20; i++) offer_word(capture_pkg::SRC_TRACE, rand_word());
      check_status();
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      repeat (40) begin
         @(negedge clk_usb_buf);
         if (led_err) seen_hi = 1'b1;
         else seen_lo = 1'b1;
      end
      check_value("led_err seen high", 32'(1'b1), 32'(seen_hi));
      check_value("led_err seen low", 32'(1'b1), 32'(seen_lo));
      bus_write(usb_bus_pkg::REG_CTRL, ctrl_byte(model_src, 1'b0, 1'b1));
      model_ovf = 1'b0;
      check_status();
      seen_hi = 1'b0;
      repeat (20) begin
         @(negedge clk_usb_buf);
         if (led_err) seen_hi = 1'b1;
      end
      check_value("led_err after clear", 32'(1'b0), 32'(seen_hi));
      for (int i = 0; i < FIFO_DEPTH; i++) read_word_check();
      check_status();
      finish_test();

      start_test("debug_flush");
      for (int i = 0; i < 5; i++) offer_word(capture_pkg::SRC_TRACE, rand_word());
      d = '0;
      d[capture_pkg::DBG_EN_BIT] = 1'b1;
      d[3:0] = capture_pkg::DBG_COUNT;
      bus_write(usb_bus_pkg::REG_DEBUG, d);
      @(negedge clk_usb_buf);
      check_value("debug oe", 32'(8'hFF), 32'(userio_oe));
      check_value("debug count view", 32'(model_q.size()), 32'(userio_d));
      d[3:0] = capture_pkg::DBG_LAST_WR;
      bus_write(usb_bus_pkg::REG_DEBUG, d);
      @(negedge clk_usb_buf);
      check_value("debug last word view", 32'(model_last[7:0]), 32'(userio_d));
      check_value("led_cap before flush", 32'(1'b1), 32'(led_cap));
      bus_write(usb_bus_pkg::REG_CTRL, ctrl_byte(model_src, 1'b1, 1'b0));
      model_q.delete();
      check_status();
      @(negedge clk_usb_buf);
      check_value("led_cap after flush", 32'(1'b0), 32'(led_cap));
      finish_test();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule

/* design/cw_capture_top.sv */
module cw_capture_top #(
   parameter int FIFO_DEPTH = 16,  // power of two, 32 at most
   parameter int FLASH_DIV  = 8
) (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [usb_bus_pkg::ADDR_W-1:0]   usb_addr_i,
   input  logic [usb_bus_pkg::DATA_W-1:0]   usb_data_i,
   input  logic                             usb_rdn_i,
   input  logic                             usb_wrn_i,
   input  logic                             usb_cen_i,
   output logic [usb_bus_pkg::DATA_W-1:0]   usb_data_o,
   output logic                             usb_data_oe_o,
   input  logic                             trace_wr_i,
   input  logic [capture_pkg::WORD_W-1:0]   trace_data_i,
   input  logic                             la_wr_i,
   input  logic [capture_pkg::WORD_W-1:0]   la_data_i,
   output logic                             led_err_o,
   output logic                             led_cap_o,
   output logic [7:0]                       userio_d_o,
   output logic [7:0]                       userio_oe_o
);

   logic [usb_bus_pkg::ADDR_W-1:0] reg_addr;
   logic [usb_bus_pkg::DATA_W-1:0] reg_wdata;
   logic [usb_bus_pkg::DATA_W-1:0] reg_rdata;
   logic                           reg_write;
   logic                           reg_read;
   logic                           fifo_rd_byte;
   logic [7:0]                     fifo_byte;
   logic                           src_sel;
   logic                           flush;
   logic                           clear_err;
   logic [5:0]                     fifo_count;
   logic                           fifo_full;
   logic                           fifo_empty;
   logic                           fifo_ovf;
   logic [capture_pkg::WORD_W-1:0] last_wr;
   logic                           debug_en;
   logic [3:0]                     debug_sel;
   logic [usb_bus_pkg::DATA_W-1:0] userio_data;
   logic [usb_bus_pkg::DATA_W-1:0] userio_dir;

   usb_reg_port u_usb_reg_port (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .usb_addr_i     (usb_addr_i),
      .usb_data_i     (usb_data_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_cen_i      (usb_cen_i),
      .reg_rdata_i    (reg_rdata),
      .fifo_byte_i    (fifo_byte),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o),
      .reg_addr_o     (reg_addr),
      .reg_wdata_o    (reg_wdata),
      .reg_write_o    (reg_write),
      .reg_read_o     (reg_read),
      .fifo_rd_byte_o (fifo_rd_byte)
   );

   ctrl_regs u_ctrl_regs (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_addr_i     (reg_addr),
      .reg_wdata_i    (reg_wdata),
      .reg_write_i    (reg_write),
      .fifo_count_i   (fifo_count),
      .fifo_full_i    (fifo_full),
      .fifo_empty_i   (fifo_empty),
      .fifo_ovf_i     (fifo_ovf),
      .reg_rdata_o    (reg_rdata),
      .src_sel_o      (src_sel),
      .flush_o        (flush),
      .clear_err_o    (clear_err),
      .debug_en_o     (debug_en),
      .debug_sel_o    (debug_sel),
      .userio_data_o  (userio_data),
      .userio_dir_o   (userio_dir)
   );

   capture_fifo #(
      .FIFO_DEPTH     (FIFO_DEPTH)
   ) u_capture_fifo (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .src_sel_i      (src_sel),
      .trace_wr_i     (trace_wr_i),
      .trace_data_i   (trace_data_i),
      .la_wr_i        (la_wr_i),
      .la_data_i      (la_data_i),
      .flush_i        (flush),
      .clear_err_i    (clear_err),
      .rd_byte_i      (fifo_rd_byte),
      .byte_o         (fifo_byte),
      .count_o        (fifo_count),
      .full_o         (fifo_full),
      .empty_o        (fifo_empty),
      .ovf_o          (fifo_ovf),
      .last_wr_o      (last_wr)
   );

   status_outputs #(
      .FLASH_DIV      (FLASH_DIV)
   ) u_status_outputs (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .fifo_ovf_i     (fifo_ovf),
      .fifo_empty_i   (fifo_empty),
      .fifo_full_i    (fifo_full),
      .fifo_count_i   (fifo_count),
      .last_wr_i      (last_wr),
      .reg_write_i    (reg_write),
      .reg_read_i     (reg_read),
      .debug_en_i     (debug_en),
      .debug_sel_i    (debug_sel),
      .userio_data_i  (userio_data),
      .userio_dir_i   (userio_dir),
      .led_err_o      (led_err_o),
      .led_cap_o      (led_cap_o),
      .userio_d_o     (userio_d_o),
      .userio_oe_o    (userio_oe_o)
   );

endmodule

/* design/status_outputs.sv */
module status_outputs #(
   parameter int FLASH_DIV = 8
) (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic                             fifo_ovf_i,
   input  logic                             fifo_empty_i,
   input  logic                             fifo_full_i,
   input  logic [5:0]                       fifo_count_i,
   input  logic [capture_pkg::WORD_W-1:0]   last_wr_i,
   input  logic                             reg_write_i,
   input  logic                             reg_read_i,
   input  logic                             debug_en_i,
   input  logic [3:0]                       debug_sel_i,
   input  logic [7:0]                       userio_data_i,
   input  logic [7:0]                       userio_dir_i,
   output logic                             led_err_o,
   output logic                             led_cap_o,
   output logic [7:0]                       userio_d_o,
   output logic [7:0]                       userio_oe_o
);

   localparam int CNT_W = (FLASH_DIV > 1) ? $clog2(FLASH_DIV) : 1;

   logic [CNT_W-1:0] flash_cnt;
   logic             flash_q;
   logic [7:0]       debug_view;

   // fast flash while the overflow flag stands
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i || !fifo_ovf_i) begin
         flash_cnt <= '0;
         flash_q   <= 1'b0;
      end else if (flash_cnt == CNT_W'(FLASH_DIV - 1)) begin
         flash_cnt <= '0;
         flash_q   <= ~flash_q;  // half period done
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
      end
   end

   assign led_err_o = fifo_ovf_i & flash_q;
   assign led_cap_o = ~fifo_empty_i;

   always_comb begin
      case (debug_sel_i)
         capture_pkg::DBG_FLAGS:
            debug_view = {reg_write_i, reg_read_i, fifo_ovf_i, fifo_full_i, fifo_empty_i, 3'b000};
         capture_pkg::DBG_COUNT:   debug_view = {2'b00, fifo_count_i};
         capture_pkg::DBG_LAST_WR: debug_view = last_wr_i[7:0];
         default:                  debug_view = 8'h00;
      endcase
   end

   // debug view takes the whole header
   assign userio_d_o  = debug_en_i ? debug_view : userio_data_i;
   assign userio_oe_o = debug_en_i ? 8'hFF : userio_dir_i;

endmodule

/* design/capture_fifo.sv */
module capture_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic                             src_sel_i,
   input  logic                             trace_wr_i,
   input  logic [capture_pkg::WORD_W-1:0]   trace_data_i,
   input  logic                             la_wr_i,
   input  logic [capture_pkg::WORD_W-1:0]   la_data_i,
   input  logic                             flush_i,
   input  logic                             clear_err_i,
   input  logic                             rd_byte_i,
   output logic [7:0]                       byte_o,
   output logic [5:0]                       count_o,
   output logic                             full_o,
   output logic                             empty_o,
   output logic                             ovf_o,
   output logic [capture_pkg::WORD_W-1:0]   last_wr_o
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [capture_pkg::WORD_W-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]                  wr_ptr;
   logic [AW-1:0]                  rd_ptr;
   logic                           hi_phase;  // next readout byte is the high one
   logic                           wr_en;
   logic [capture_pkg::WORD_W-1:0] wr_data;
   logic [capture_pkg::WORD_W-1:0] head;
   logic                           push;
   logic                           pop;

   // only the selected source reaches the buffer
   assign wr_en   = (src_sel_i == capture_pkg::SRC_LA) ? la_wr_i : trace_wr_i;
   assign wr_data = (src_sel_i == capture_pkg::SRC_LA) ? la_data_i : trace_data_i;

   assign full_o  = (count_o == 6'(FIFO_DEPTH));
   assign empty_o = (count_o == '0);
   assign push    = wr_en && !full_o && !flush_i;
   assign pop     = rd_byte_i && hi_phase && !empty_o;  // after the high byte

   assign head   = mem[rd_ptr];
   assign byte_o = empty_o  ? 8'h00 :
                   hi_phase ? head[capture_pkg::WORD_W-1 -: 8] : head[7:0];

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
         last_wr_o   <= wr_data;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i || flush_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count_o  <= '0;
         hi_phase <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (rd_byte_i && !empty_o) begin
            hi_phase <= ~hi_phase;  // empty reads leave the phase alone
         end
         case ({push, pop})
            2'b10:   count_o <= count_o + 6'd1;
            2'b01:   count_o <= count_o - 6'd1;
            default: ;
         endcase
      end
   end

   // sticky overflow, flush keeps it
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         ovf_o <= 1'b0;
      end else if (clear_err_i) begin
         ovf_o <= 1'b0;
      end else if (wr_en && full_o) begin
         ovf_o <= 1'b1;  // dropped word
      end
   end

endmodule

/* design/ctrl_regs.sv */
module ctrl_regs (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [usb_bus_pkg::ADDR_W-1:0]   reg_addr_i,
   input  logic [usb_bus_pkg::DATA_W-1:0]   reg_wdata_i,
   input  logic                             reg_write_i,
   input  logic [5:0]                       fifo_count_i,
   input  logic                             fifo_full_i,
   input  logic                             fifo_empty_i,
   input  logic                             fifo_ovf_i,
   output logic [usb_bus_pkg::DATA_W-1:0]   reg_rdata_o,
   output logic                             src_sel_o,
   output logic                             flush_o,
   output logic                             clear_err_o,
   output logic                             debug_en_o,
   output logic [3:0]                       debug_sel_o,
   output logic [usb_bus_pkg::DATA_W-1:0]   userio_data_o,
   output logic [usb_bus_pkg::DATA_W-1:0]   userio_dir_o
);

   logic [usb_bus_pkg::DATA_W-1:0] debug_q;
   logic [usb_bus_pkg::DATA_W-1:0] ctrl_rd;
   logic [usb_bus_pkg::DATA_W-1:0] status_rd;
   logic                           ctrl_wr;

   assign ctrl_wr = reg_write_i && (reg_addr_i == usb_bus_pkg::REG_CTRL);

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         src_sel_o     <= capture_pkg::SRC_TRACE;
         debug_q       <= '0;
         userio_data_o <= '0;
         userio_dir_o  <= '0;
      end else if (reg_write_i) begin
         case (reg_addr_i)
            usb_bus_pkg::REG_CTRL:        src_sel_o <= reg_wdata_i[usb_bus_pkg::CTRL_SRC_BIT];
            usb_bus_pkg::REG_DEBUG:       debug_q <= reg_wdata_i;
            usb_bus_pkg::REG_USERIO_DATA: userio_data_o <= reg_wdata_i;
            usb_bus_pkg::REG_USERIO_DIR:  userio_dir_o <= reg_wdata_i;
            default: ;  // status and fifo are read only
         endcase
      end
   end

   // command bits last one cycle, one cycle after the write pulse
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         flush_o     <= 1'b0;
         clear_err_o <= 1'b0;
      end else begin
         flush_o     <= ctrl_wr && reg_wdata_i[usb_bus_pkg::CTRL_FLUSH_BIT];
         clear_err_o <= ctrl_wr && reg_wdata_i[usb_bus_pkg::CTRL_CLR_ERR_BIT];
      end
   end

   assign debug_en_o  = debug_q[capture_pkg::DBG_EN_BIT];
   assign debug_sel_o = debug_q[3:0];

   always_comb begin
      ctrl_rd                               = '0;
      ctrl_rd[usb_bus_pkg::CTRL_SRC_BIT]    = src_sel_o;  // command bits read as 0
      status_rd                             = '0;
      status_rd[7:3]                        = fifo_count_i[4:0];
      status_rd[capture_pkg::STAT_OVF]      = fifo_ovf_i;
      status_rd[capture_pkg::STAT_FULL]     = fifo_full_i;
      status_rd[capture_pkg::STAT_EMPTY]    = fifo_empty_i;
      case (reg_addr_i)
         usb_bus_pkg::REG_CTRL:        reg_rdata_o = ctrl_rd;
         usb_bus_pkg::REG_DEBUG:       reg_rdata_o = debug_q;
         usb_bus_pkg::REG_USERIO_DATA: reg_rdata_o = userio_data_o;
         usb_bus_pkg::REG_USERIO_DIR:  reg_rdata_o = userio_dir_o;
         usb_bus_pkg::REG_STATUS:      reg_rdata_o = status_rd;
         default:                      reg_rdata_o = '0;  // unmapped
      endcase
   end

endmodule

/* design/usb_reg_port.sv */
module usb_reg_port (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [usb_bus_pkg::ADDR_W-1:0]   usb_addr_i,
   input  logic [usb_bus_pkg::DATA_W-1:0]   usb_data_i,
   input  logic                             usb_rdn_i,
   input  logic                             usb_wrn_i,
   input  logic                             usb_cen_i,
   input  logic [usb_bus_pkg::DATA_W-1:0]   reg_rdata_i,
   input  logic [usb_bus_pkg::DATA_W-1:0]   fifo_byte_i,
   output logic [usb_bus_pkg::DATA_W-1:0]   usb_data_o,
   output logic                             usb_data_oe_o,
   output logic [usb_bus_pkg::ADDR_W-1:0]   reg_addr_o,
   output logic [usb_bus_pkg::DATA_W-1:0]   reg_wdata_o,
   output logic                             reg_write_o,
   output logic                             reg_read_o,
   output logic                             fifo_rd_byte_o
);

   logic rdn_q;
   logic rdn_prev;
   logic wrn_q;
   logic wrn_prev;
   logic cen_q;
   logic rd_fall;
   logic wr_fall;

   // falling strobe while chip enable is low
   assign rd_fall = rdn_prev & ~rdn_q & ~cen_q;
   assign wr_fall = wrn_prev & ~wrn_q & ~cen_q;

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         rdn_q    <= 1'b1;
         rdn_prev <= 1'b1;
         wrn_q    <= 1'b1;
         wrn_prev <= 1'b1;
         cen_q    <= 1'b1;
      end else begin
         rdn_q    <= usb_rdn_i;  // single sampling stage
         rdn_prev <= rdn_q;
         wrn_q    <= usb_wrn_i;
         wrn_prev <= wrn_q;
         cen_q    <= usb_cen_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         reg_write_o    <= 1'b0;
         reg_read_o     <= 1'b0;
         fifo_rd_byte_o <= 1'b0;
      end else begin
         reg_write_o    <= wr_fall;
         reg_read_o     <= rd_fall;
         fifo_rd_byte_o <= rd_fall && (usb_addr_i == usb_bus_pkg::REG_FIFO_DATA);
      end
   end

   // host holds address and data stable for the whole access
   always_ff @(posedge clk_usb_buf) begin
      if (rd_fall || wr_fall) begin
         reg_addr_o  <= usb_addr_i;
         reg_wdata_o <= usb_data_i;
      end
   end

   // fifo byte taken before the pop lands on the same edge
   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_o) begin
         usb_data_o <= (reg_addr_o == usb_bus_pkg::REG_FIFO_DATA) ? fifo_byte_i : reg_rdata_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         usb_data_oe_o <= 1'b0;
      end else if (reg_read_o) begin
         usb_data_oe_o <= 1'b1;
      end else if (rdn_q) begin
         usb_data_oe_o <= 1'b0;  // released 2 cycles after rdn rises
      end
   end

endmodule

/* design/capture_pkg.sv */
package capture_pkg;

   // capture FIFO word
   localparam int unsigned WORD_W = 16;

   // source select codes, REG_CTRL source bit
   localparam logic SRC_TRACE = 1'b0;
   localparam logic SRC_LA    = 1'b1;

   // REG_DEBUG layout, view code lives in bits 3..0
   localparam int unsigned DBG_EN_BIT = 4;

   localparam logic [3:0] DBG_FLAGS   = 4'h0;  // strobes and fifo flags
   localparam logic [3:0] DBG_COUNT   = 4'h1;  // fifo word count
   localparam logic [3:0] DBG_LAST_WR = 4'h2;  // low byte of last accepted word

   // REG_STATUS bit positions, count sits in bits 7..3
   localparam int unsigned STAT_EMPTY = 0;
   localparam int unsigned STAT_FULL  = 1;
   localparam int unsigned STAT_OVF   = 2;

endpackage

/* design/usb_bus_pkg.sv */
package usb_bus_pkg;

   // microcontroller bus geometry
   localparam int unsigned ADDR_W = 8;
   localparam int unsigned DATA_W = 8;

   // register map
   localparam logic [ADDR_W-1:0] REG_CTRL        = 8'h20;  // source select and commands
   localparam logic [ADDR_W-1:0] REG_DEBUG       = 8'h21;  // debug enable and view code
   localparam logic [ADDR_W-1:0] REG_USERIO_DATA = 8'h22;
   localparam logic [ADDR_W-1:0] REG_USERIO_DIR  = 8'h23;  // 1 = driven by fpga
   localparam logic [ADDR_W-1:0] REG_STATUS      = 8'h24;  // read only
   localparam logic [ADDR_W-1:0] REG_FIFO_DATA   = 8'h25;  // bypasses register readback

   // REG_CTRL bit positions
   localparam int unsigned CTRL_SRC_BIT     = 0;  // level, reads back
   localparam int unsigned CTRL_FLUSH_BIT   = 1;  // self clearing
   localparam int unsigned CTRL_CLR_ERR_BIT = 2;  // self clearing

endpackage
